// File: logic/dbg_defines.svh
// Debug terminal sizing constants
// Line length, timestamp width and digit count, accelerometer width

`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// Characters per debug line, carriage return included
`define DBG_MSG_LEN 64

// Raw timer count width
`define DBG_TS_BITS 24

// Decimal digits out of the timestamp converter
// 24 bits tops out at 16777215, so eight digits
`define DBG_TS_DIGITS 8

// Three axes of 16 bits each
`define DBG_ACC_BITS 48

`endif

// File: logic/dbg_pkg.sv
// Debug terminal types
// Vector typedefs for the line data and the two FSM state encodings

`default_nettype none

`include "dbg_defines.svh"

package dbg_pkg;

  // One ASCII character on the link
  typedef logic [7:0] char_t;

  // Raw timer count and accelerometer word
  typedef logic [`DBG_TS_BITS-1:0] timestamp_t;
  typedef logic [`DBG_ACC_BITS-1:0] acc_t;

  // Packed decimal digits, digit 0 in the low nibble
  typedef logic [4*`DBG_TS_DIGITS-1:0] bcd_t;

  // Character index within a line
  typedef logic [$clog2(`DBG_MSG_LEN)-1:0] msg_addr_t;

  // Message sender FSM
  typedef enum logic [0:0] {
    TX_IDLE,
    TX_MSG
  } tx_state_e;

  // Command decoder FSM, one action state per command
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_RESET,
    CMD_MOTOR,
    CMD_DATA
  } cmd_state_e;

endpackage

`default_nettype wire

// File: logic/bin2bcd.sv
// Binary to packed BCD converter
// Combinational shift-and-add-three, one pass per input bit

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module bin2bcd #(
  parameter int BITS = 24
) (
  input  dbg_pkg::timestamp_t bin,
  output dbg_pkg::bcd_t       bcd
);

  // Working digit register for the double dabble
  dbg_pkg::bcd_t acc_bcd;

  always_comb begin
    acc_bcd = '0;

    // MSB first, one shift per input bit
    for (int i = BITS - 1; i >= 0; i--) begin

      // Correct every digit that would overflow on the shift
      for (int d = 0; d < `DBG_TS_DIGITS; d++) begin
        if (acc_bcd[4*d +: 4] >= 4'd5) begin
          acc_bcd[4*d +: 4] = acc_bcd[4*d +: 4] + 4'd3;
        end
      end

      // Pull in the next binary bit
      acc_bcd = {acc_bcd[4*`DBG_TS_DIGITS-2:0], bin[i]};
    end
  end

  // Upper digits stay zero for small values
  assign bcd = acc_bcd;

endmodule

`default_nettype wire

// File: logic/debug_msg_sender.sv
// Debug line sender
// Latches timestamp and accelerometer data on the timer pulse, then
// streams the 64-character text line one byte per free tx slot

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module debug_msg_sender (
  input  logic                clk,
  input  logic                rst,
  input  logic                tmr,
  input  dbg_pkg::timestamp_t timestamp,
  input  dbg_pkg::acc_t       acc,
  input  dbg_pkg::bcd_t       ts_bcd,
  input  logic                motor_armed,
  input  logic                data_logging,
  input  logic                tx_busy,
  output dbg_pkg::timestamp_t ts_latched,
  output dbg_pkg::char_t      tx_data,
  output logic                new_tx_data
);

  // Last character index of a line
  localparam dbg_pkg::msg_addr_t LAST_ADDR = dbg_pkg::msg_addr_t'(`DBG_MSG_LEN - 1);

  // ASCII zero, added to each BCD digit
  localparam dbg_pkg::char_t ASCII_ZERO = 8'h30;

  dbg_pkg::tx_state_e state;
  dbg_pkg::msg_addr_t addr;

  // Accelerometer word as captured at line start
  dbg_pkg::acc_t acc_latched;

  // Full line as seen for the current captured data
  dbg_pkg::char_t msg [`DBG_MSG_LEN];

  // Start of a new line
  logic start;

  assign start = (state == dbg_pkg::TX_IDLE) && tmr;

  // One byte goes out per cycle the transmitter is free
  assign new_tx_data = (state == dbg_pkg::TX_MSG) && !tx_busy;

  // Sender FSM and character index
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dbg_pkg::TX_IDLE;
      addr  <= '0;
    end else begin
      case (state)
        dbg_pkg::TX_IDLE: begin
          addr <= '0;
          if (tmr) begin
            state <= dbg_pkg::TX_MSG;
          end
        end
        dbg_pkg::TX_MSG: begin
          // Index holds while the transmitter is busy
          if (!tx_busy) begin
            addr <= addr + 1'b1;
            if (addr == LAST_ADDR) begin
              state <= dbg_pkg::TX_IDLE;
            end
          end
        end
        default: state <= dbg_pkg::TX_IDLE;
      endcase
    end
  end

  // Capture so the whole line is self-consistent
  always_ff @(posedge clk) begin
    if (start) begin
      ts_latched  <= timestamp;
      acc_latched <= acc;
    end
  end

  // Line layout
  always_comb begin
    // Spaces everywhere a field does not land
    for (int i = 0; i < `DBG_MSG_LEN; i++) begin
      msg[i] = " ";
    end

    // Timestamp as ddd.d, digits 5 to 2
    msg[1] = ASCII_ZERO + {4'd0, ts_bcd[4*5 +: 4]};
    msg[2] = ASCII_ZERO + {4'd0, ts_bcd[4*4 +: 4]};
    msg[3] = ASCII_ZERO + {4'd0, ts_bcd[4*3 +: 4]};
    msg[4] = ".";
    msg[5] = ASCII_ZERO + {4'd0, ts_bcd[4*2 +: 4]};

    // Accelerometer bits MSB first, a space after every eight
    for (int k = 0; k < `DBG_ACC_BITS; k++) begin
      msg[7 + k + k / 8] = acc_latched[`DBG_ACC_BITS - 1 - k] ? "1" : "0";
    end

    // Flags read live, then end of line
    msg[61] = motor_armed ? "A" : "D";
    msg[62] = data_logging ? "R" : "I";
    msg[63] = 8'h0d;
  end

  // Character at the current index
  assign tx_data = msg[addr];

endmodule

`default_nettype wire

// File: logic/terminal_cmd_decoder.sv
// Terminal command decoder
// "m" toggles motor arm, "d" toggles datalog, "r" pulses board reset

`timescale 1ns/1ps
`default_nettype none

module terminal_cmd_decoder (
  input  logic           clk,
  input  logic           rst,
  input  logic           new_rx_data,
  input  dbg_pkg::char_t rx_data,
  output logic           motor_armed,
  output logic           data_logging,
  output logic           board_reset
);

  dbg_pkg::cmd_state_e state;

  // Decoder FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dbg_pkg::CMD_IDLE;
    end else begin
      case (state)
        dbg_pkg::CMD_IDLE: begin
          // Unknown characters are ignored
          if (new_rx_data) begin
            case (rx_data)
              "r": state <= dbg_pkg::CMD_RESET;
              "m": state <= dbg_pkg::CMD_MOTOR;
              "d": state <= dbg_pkg::CMD_DATA;
              default: state <= dbg_pkg::CMD_IDLE;
            endcase
          end
        end
        // Action states last one cycle, strobes here are dropped
        dbg_pkg::CMD_RESET,
        dbg_pkg::CMD_MOTOR,
        dbg_pkg::CMD_DATA: state <= dbg_pkg::CMD_IDLE;
        default: state <= dbg_pkg::CMD_IDLE;
      endcase
    end
  end

  // Flags and reset request
  always_ff @(posedge clk) begin
    if (rst) begin
      motor_armed  <= 1'b0;
      data_logging <= 1'b0;
      board_reset  <= 1'b0;
    end else begin
      if (state == dbg_pkg::CMD_MOTOR) begin
        motor_armed <= !motor_armed;
      end
      if (state == dbg_pkg::CMD_DATA) begin
        data_logging <= !data_logging;
      end
      // Single cycle request, out of a register
      board_reset <= (state == dbg_pkg::CMD_RESET);
    end
  end

endmodule

`default_nettype wire

// File: logic/debug_terminal.sv
// Debug terminal top level
// Periodic sensor line out to the USB micro, command characters back in

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module debug_terminal (
  input  logic                clk,
  input  logic                rst,
  input  logic                tmr,
  input  dbg_pkg::timestamp_t timestamp,
  input  dbg_pkg::acc_t       acc,
  input  dbg_pkg::char_t      rx_data,
  input  logic                new_rx_data,
  input  logic                tx_busy,
  output dbg_pkg::char_t      tx_data,
  output logic                new_tx_data,
  output logic                motor_armed,
  output logic                data_logging,
  output logic                board_reset
);

  // Captured timestamp and its decimal form
  dbg_pkg::timestamp_t ts_latched;
  dbg_pkg::bcd_t       ts_bcd;

  bin2bcd #(
    .BITS(`DBG_TS_BITS)
  ) u_bin2bcd (
    .bin(ts_latched),
    .bcd(ts_bcd)
  );

  // Line sender, flags come from the decoder
  debug_msg_sender u_sender (
    .clk(clk),
    .rst(rst),
    .tmr(tmr),
    .timestamp(timestamp),
    .acc(acc),
    .ts_bcd(ts_bcd),
    .motor_armed(motor_armed),
    .data_logging(data_logging),
    .tx_busy(tx_busy),
    .ts_latched(ts_latched),
    .tx_data(tx_data),
    .new_tx_data(new_tx_data)
  );

  terminal_cmd_decoder u_decoder (
    .clk(clk),
    .rst(rst),
    .new_rx_data(new_rx_data),
    .rx_data(rx_data),
    .motor_armed(motor_armed),
    .data_logging(data_logging),
    .board_reset(board_reset)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock source
// Free-running 40 ns clock, starts low

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // Half of the 40 ns period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tests/debug_terminal_checker.sv
// Debug terminal protocol assertions
// Transmit strobe against busy, reset pulse width, motor flag source

`timescale 1ns/1ps
`default_nettype none

module debug_terminal_checker (
  input logic                clk,
  input logic                rst,
  input logic                new_tx_data,
  input logic                tx_busy,
  input logic                board_reset,
  input logic                motor_armed,
  input dbg_pkg::cmd_state_e cmd_state
);

  // Failed assertions so far
  int fail_count = 0;

  // No byte while the transmitter is still sending
  tx_while_busy: assert property (@(posedge clk) disable iff (rst)
    !(new_tx_data && tx_busy))
    else begin
      fail_count++;
      $error("new_tx_data high while tx_busy high");
    end

  // Reset request is a single cycle
  reset_one_cycle: assert property (@(posedge clk) disable iff (rst)
    board_reset |=> !board_reset)
    else begin
      fail_count++;
      $error("board_reset held for two cycles");
    end

  // Motor flag moves only right after the motor state
  motor_source: assert property (@(posedge clk) disable iff (rst)
    (motor_armed != $past(motor_armed)) |-> ($past(cmd_state) == dbg_pkg::CMD_MOTOR))
    else begin
      fail_count++;
      $error("motor_armed changed outside the motor command");
    end

endmodule

bind debug_terminal debug_terminal_checker chk0 (
  .clk(clk),
  .rst(rst),
  .new_tx_data(new_tx_data),
  .tx_busy(tx_busy),
  .board_reset(board_reset),
  .motor_armed(motor_armed),
  .cmd_state(u_decoder.state)
);

`default_nettype wire

// File: tests/debug_terminal_tb.sv
// Debug terminal testbench
// Replays line and command vectors, models the transmitter busy level
// and checks every byte of each debug line against the layout

`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module debug_terminal_tb;

  logic                clk;
  logic                rst;
  logic                tmr;
  dbg_pkg::timestamp_t timestamp;
  dbg_pkg::acc_t       acc;
  dbg_pkg::char_t      rx_data;
  logic                new_rx_data;
  logic                tx_busy;
  dbg_pkg::char_t      tx_data;
  logic                new_tx_data;
  logic                motor_armed;
  logic                data_logging;
  logic                board_reset;

  // Counters for the summary
  int checks = 0;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;

  logic [31:0] rand_state = 32'he1fc;

  // Flags the next line should show
  logic exp_motor = 1'b0;
  logic exp_data = 1'b0;

  tb_clock clk_gen (.clk(clk));

  debug_terminal dut0 (
    .clk(clk),
    .rst(rst),
    .tmr(tmr),
    .timestamp(timestamp),
    .acc(acc),
    .rx_data(rx_data),
    .new_rx_data(new_rx_data),
    .tx_busy(tx_busy),
    .tx_data(tx_data),
    .new_tx_data(new_tx_data),
    .motor_armed(motor_armed),
    .data_logging(data_logging),
    .board_reset(board_reset)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reference character for one position of the line
  function automatic dbg_pkg::char_t expected_char(input int idx, input dbg_pkg::timestamp_t ts,
                                                   input dbg_pkg::acc_t a, input logic motor,
                                                   input logic data);
    int digit;
    int v;
    int k;
    dbg_pkg::char_t c;
    c = " ";
    if (idx == 4) begin
      c = ".";
    end else if (idx >= 1 && idx <= 5) begin
      // Index 1 is digit 5, index 5 is digit 2
      digit = (idx == 5) ? 2 : 6 - idx;
      v = int'(ts);
      for (int j = 0; j < digit; j++) begin
        v = v / 10;
      end
      c = 8'h30 + 8'(v % 10);
    end else if (idx >= 7 && idx <= 59 && (idx - 7) % 9 != 8) begin
      // Groups of eight bits, nine positions apart
      k = (idx - 7) - (idx - 7) / 9;
      c = a[`DBG_ACC_BITS - 1 - k] ? "1" : "0";
    end else if (idx == 61) begin
      c = motor ? "A" : "D";
    end else if (idx == 62) begin
      c = data ? "R" : "I";
    end else if (idx == 63) begin
      c = 8'h0d;
    end
    return c;
  endfunction

  task automatic check_char(input string name, input dbg_pkg::char_t exp,
                            input dbg_pkg::char_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before) begin
      failed_tests++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  // New sensor values from the LCG
  task automatic scramble_inputs();
    rand_state = next_random(rand_state);
    timestamp = rand_state[31:8];
    rand_state = next_random(rand_state);
    acc = {rand_state[31:16], rand_state};
  endtask

  // One debug line with the busy model running
  task automatic run_line(input string name, input dbg_pkg::timestamp_t ts,
                          input dbg_pkg::acc_t a, input int busy_len);
    dbg_pkg::char_t got [`DBG_MSG_LEN];
    int count;
    int cycles;
    int busy_left;
    int limit;
    logic mid_sent;
    logic extra_seen;
    count = 0;
    cycles = 0;
    busy_left = 0;
    mid_sent = 1'b0;
    extra_seen = 1'b0;
    limit = `DBG_MSG_LEN * (busy_len + 5) + 40;
    while (count < `DBG_MSG_LEN && cycles < limit) begin
      @(negedge clk);
      // Busy for a while after each accepted byte
      tx_busy = (busy_left > 0);
      if (busy_left > 0) begin
        busy_left--;
      end
      tmr = 1'b0;
      if (cycles == 0) begin
        timestamp = ts;
        acc = a;
        tmr = 1'b1;
      end else if (cycles == 1) begin
        scramble_inputs();
      end else if (count == 32 && !mid_sent) begin
        // Stray timer pulse and fresh inputs mid-line
        scramble_inputs();
        tmr = 1'b1;
        mid_sent = 1'b1;
      end
      #5;
      if (new_tx_data) begin
        got[count] = tx_data;
        count++;
        if (busy_len > 0) begin
          rand_state = next_random(rand_state);
          busy_left = busy_len + int'(rand_state[30:29]);
        end
      end
      cycles++;
    end
    tmr = 1'b0;
    if (count < `DBG_MSG_LEN) begin
      errors++;
      $display("Timeout: %s sent only %0d of %0d bytes", name, count, `DBG_MSG_LEN);
    end else begin
      for (int i = 0; i < `DBG_MSG_LEN; i++) begin
        check_char($sformatf("%s char %0d", name, i),
                   expected_char(i, ts, a, exp_motor, exp_data), got[i]);
      end
    end
    // Nothing more after the carriage return
    repeat (12) begin
      @(negedge clk);
      tx_busy = (busy_left > 0);
      if (busy_left > 0) begin
        busy_left--;
      end
      #5;
      if (new_tx_data) begin
        extra_seen = 1'b1;
      end
    end
    tx_busy = 1'b0;
    check_flag({name, " extra bytes"}, 1'b0, extra_seen);
  endtask

  // One command character at the fixed decoder latency
  task automatic run_cmd(input string name, input dbg_pkg::char_t c, input logic m,
                         input logic d, input logic r);
    @(negedge clk);
    rx_data = c;
    new_rx_data = 1'b1;
    @(negedge clk);
    check_flag({name, " motor before"}, exp_motor, motor_armed);
    check_flag({name, " datalog before"}, exp_data, data_logging);
    check_flag({name, " reset before"}, 1'b0, board_reset);
    new_rx_data = 1'b0;
    @(negedge clk);
    check_flag({name, " motor"}, m, motor_armed);
    check_flag({name, " datalog"}, d, data_logging);
    check_flag({name, " reset"}, r, board_reset);
    @(negedge clk);
    check_flag({name, " reset after"}, 1'b0, board_reset);
    exp_motor = m;
    exp_data = d;
    repeat (2) @(negedge clk);
  endtask

  initial begin
    string line;
    int fd;
    int rc;
    int n;
    int rec;
    int errs_before;
    int busy_v;
    int m_v;
    int d_v;
    int r_v;
    logic seen;
    dbg_pkg::timestamp_t ts_v;
    dbg_pkg::acc_t acc_v;
    dbg_pkg::char_t c_v;
    rst = 1'b1;
    tmr = 1'b0;
    timestamp = '0;
    acc = '0;
    rx_data = '0;
    new_rx_data = 1'b0;
    tx_busy = 1'b0;
    rec = 0;
    seen = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // Quiet after reset
    errs_before = errors;
    check_flag("reset_idle new_tx_data", 1'b0, new_tx_data);
    check_flag("reset_idle board_reset", 1'b0, board_reset);
    check_flag("reset_idle motor_armed", 1'b0, motor_armed);
    check_flag("reset_idle data_logging", 1'b0, data_logging);
    repeat (20) begin
      @(negedge clk);
      if (new_tx_data) begin
        seen = 1'b1;
      end
    end
    check_flag("reset_idle no bytes", 1'b0, seen);
    end_test("reset_idle", errs_before);

    fd = $fopen("tests/debug_terminal_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the vector file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc == 0 || line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        errs_before = errors;
        if (line.getc(0) == "L") begin
          n = $sscanf(line, "L %h %h %d", ts_v, acc_v, busy_v);
          if (n != 3) begin
            errors++;
            $display("Malformed line record %0d in the vector file", rec);
          end else begin
            run_line($sformatf("line_%0d", rec), ts_v, acc_v, busy_v);
          end
          end_test($sformatf("line_%0d", rec), errs_before);
        end else begin
          n = $sscanf(line, "C %h %d %d %d", c_v, m_v, d_v, r_v);
          if (n != 4) begin
            errors++;
            $display("Malformed command record %0d in the vector file", rec);
          end else begin
            run_cmd($sformatf("cmd_%0d", rec), c_v, m_v != 0, d_v != 0, r_v != 0);
          end
          end_test($sformatf("cmd_%0d", rec), errs_before);
        end
        rec++;
      end
      $fclose(fd);
    end

    $display("Summary: %0d tests, %0d failing, %0d compares, %0d mismatches, %0d assertion errors",
             tests, failed_tests, checks, errors, dut0.chk0.fail_count);
    if (errors == 0 && dut0.chk0.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog on the whole run
  initial begin
    #2000000;
    $display("Simulation did not finish within the time limit");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/dbg_pkg.sv
logic/bin2bcd.sv
logic/debug_msg_sender.sv
logic/terminal_cmd_decoder.sv
logic/debug_terminal.sv
tests/tb_clock.sv
tests/debug_terminal_checker.sv
tests/debug_terminal_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug terminal testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f verilog.f --top-module debug_terminal_tb \
  -Mdir obj_dir -o debug_terminal_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep going after an assertion error so the testbench can report it
./obj_dir/debug_terminal_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: tests/debug_terminal_vectors.txt
# L <timestamp hex> <acc hex> <busy cycles after each byte, 0 for none>
# C <character hex> <expected motor> <expected datalog> <expected board reset>
L 000000 000000000000 0
L 003039 a5a55a5a0ff0 0
L ffffff ffffffffffff 2
L 98967f 123456789abc 3
C 6d 1 0 0
C 64 1 1 0
L 0f4240 00ff00ff00ff 1
C 72 1 1 1
C 78 1 1 0
C 41 1 1 0
L 00beef fedcba987654 0
C 6d 0 1 0
L 7a1200 0000ffff0000 4
C 64 0 0 0
C 72 0 0 1
L 123456 800000000001 1
C 6d 1 0 0
C 4d 1 0 0
L 000009 c3c3c3c3c3c3 2
C 64 1 1 0
L 5f5e0f 0123456789ab 0
